// File: hw/decoder_params.svh
/*
 * Widths are fixed by the 6502 and are not meant to be changed.
 * The T-state counter only reaches T3 since T4..T7 sequences are not decoded.
 */
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// instruction register and data byte width
`define DEC_IR_W 8

// T-state counter width, kept at the full 6502 size
`define DEC_TCU_W 4

// carry flag position in P
`define DEC_P_CARRY 0

// last T-state of each instruction length
`define DEC_LEN_SHORT 1
`define DEC_LEN_ABS 3

`endif

// File: hw/mos6502_op_pkg.sv
/*
 * Opcode side of the decoder: only the decoded subset of the 6502 is listed.
 * Any other IR value is treated as a two-cycle unknown instruction.
 */
`include "decoder_params.svh"

package mos6502_op_pkg;

    // opcode values as fetched into IR
    typedef enum logic [`DEC_IR_W-1:0] {
        op_nop   = 8'hea,
        op_tax   = 8'haa,
        op_tay   = 8'ha8,
        op_txa   = 8'h8a,
        op_tya   = 8'h98,
        op_txs   = 8'h9a,
        op_tsx   = 8'hba,
        op_inx   = 8'he8,
        op_iny   = 8'hc8,
        op_dex   = 8'hca,
        op_dey   = 8'h88,
        op_asl_a = 8'h0a,
        op_lsr_a = 8'h4a,
        op_rol_a = 8'h2a,
        op_ror_a = 8'h6a,
        op_sec   = 8'h38,
        op_clc   = 8'h18,
        op_sei   = 8'h78,
        op_cli   = 8'h58,
        op_clv   = 8'hb8,
        op_lda_i = 8'ha9,
        op_ldx_i = 8'ha2,
        op_ldy_i = 8'ha0,
        op_and_i = 8'h29,
        op_lda_a = 8'had,
        op_ldx_a = 8'hae,
        op_ldy_a = 8'hac,
        op_sta_a = 8'h8d
    } opcode_e;

    typedef enum logic [3:0] {
        cls_nop,
        cls_transfer,
        cls_incdec,
        cls_shift,
        cls_flag,
        cls_load_imm,
        cls_and_imm,
        cls_load_abs,
        cls_store_abs,
        cls_unknown
    } op_class_e;

    typedef enum logic [2:0] {reg_none, reg_ac, reg_x, reg_y, reg_s} reg_sel_e;

    typedef enum logic [2:0] {
        alu_none, alu_inc, alu_dec, alu_asl, alu_lsr, alu_rol, alu_ror, alu_and
    } alu_op_e;

endpackage

// File: hw/mos6502_ctl_pkg.sv
/*
 * Control side of the decoder: timing state, data and status types.
 * P follows the 6502 bit order, carry in bit 0.
 */
`include "decoder_params.svh"

package mos6502_ctl_pkg;

    // timing state, T0 is the opcode fetch
    typedef logic [`DEC_TCU_W-1:0] tcu_t;

    // one byte on the data bus, same width as IR
    typedef logic [`DEC_IR_W-1:0] byte_t;

    // processor status register
    typedef logic [`DEC_IR_W-1:0] pstat_t;

    // level of the R/W pin
    typedef enum logic {
        rw_write = 1'b0,
        rw_read  = 1'b1
    } rw_e;

endpackage

// File: hw/decode_state_if.sv
/*
 * Decode state shared by the control generators.
 * All fields are valid in the same cycle as the T-state they go with.
 */
`timescale 1ns/10ps

interface decode_state_if;

    mos6502_op_pkg::op_class_e op_class;
    mos6502_op_pkg::reg_sel_e  src_reg;
    mos6502_op_pkg::reg_sel_e  dst_reg;
    mos6502_op_pkg::alu_op_e   alu_op;
    mos6502_ctl_pkg::tcu_t     tcu;
    // carry into the adder for rotates, 0 for all else
    logic                      carry_in;

    modport classifier (output op_class, src_reg, dst_reg, alu_op);
    modport sequencer  (input op_class, alu_op, output tcu, carry_in);
    modport route      (input op_class, src_reg, dst_reg, alu_op, tcu, carry_in);
    modport alu        (input op_class, src_reg, dst_reg, alu_op, tcu, carry_in);

endinterface

// File: hw/opcode_classifier.sv
/*
 * Purely combinational decode of IR into class, registers and ALU operation.
 * Flag instructions name their target flag through dst_reg.
 */
`timescale 1ns/10ps

module opcode_classifier (
    input  mos6502_ctl_pkg::byte_t     i_ir,
    decode_state_if.classifier         ds
);

    always_comb begin
        case (i_ir)
        mos6502_op_pkg::op_nop: ds.op_class = mos6502_op_pkg::cls_nop;
        mos6502_op_pkg::op_tax, mos6502_op_pkg::op_tay, mos6502_op_pkg::op_txa,
        mos6502_op_pkg::op_tya, mos6502_op_pkg::op_txs, mos6502_op_pkg::op_tsx:
            ds.op_class = mos6502_op_pkg::cls_transfer;
        mos6502_op_pkg::op_inx, mos6502_op_pkg::op_iny,
        mos6502_op_pkg::op_dex, mos6502_op_pkg::op_dey:
            ds.op_class = mos6502_op_pkg::cls_incdec;
        mos6502_op_pkg::op_asl_a, mos6502_op_pkg::op_lsr_a,
        mos6502_op_pkg::op_rol_a, mos6502_op_pkg::op_ror_a:
            ds.op_class = mos6502_op_pkg::cls_shift;
        mos6502_op_pkg::op_sec, mos6502_op_pkg::op_clc, mos6502_op_pkg::op_sei,
        mos6502_op_pkg::op_cli, mos6502_op_pkg::op_clv:
            ds.op_class = mos6502_op_pkg::cls_flag;
        mos6502_op_pkg::op_lda_i, mos6502_op_pkg::op_ldx_i, mos6502_op_pkg::op_ldy_i:
            ds.op_class = mos6502_op_pkg::cls_load_imm;
        mos6502_op_pkg::op_and_i: ds.op_class = mos6502_op_pkg::cls_and_imm;
        mos6502_op_pkg::op_lda_a, mos6502_op_pkg::op_ldx_a, mos6502_op_pkg::op_ldy_a:
            ds.op_class = mos6502_op_pkg::cls_load_abs;
        mos6502_op_pkg::op_sta_a: ds.op_class = mos6502_op_pkg::cls_store_abs;
        default: ds.op_class = mos6502_op_pkg::cls_unknown;
        endcase
    end

    // register driven onto SB, or stored by STA
    always_comb begin
        case (i_ir)
        mos6502_op_pkg::op_tax, mos6502_op_pkg::op_tay, mos6502_op_pkg::op_and_i,
        mos6502_op_pkg::op_asl_a, mos6502_op_pkg::op_lsr_a,
        mos6502_op_pkg::op_rol_a, mos6502_op_pkg::op_ror_a, mos6502_op_pkg::op_sta_a:
            ds.src_reg = mos6502_op_pkg::reg_ac;
        mos6502_op_pkg::op_txa, mos6502_op_pkg::op_txs,
        mos6502_op_pkg::op_inx, mos6502_op_pkg::op_dex:
            ds.src_reg = mos6502_op_pkg::reg_x;
        mos6502_op_pkg::op_tya, mos6502_op_pkg::op_iny, mos6502_op_pkg::op_dey:
            ds.src_reg = mos6502_op_pkg::reg_y;
        mos6502_op_pkg::op_tsx: ds.src_reg = mos6502_op_pkg::reg_s;
        default: ds.src_reg = mos6502_op_pkg::reg_none;
        endcase
    end

    // flag class: ac selects C, s selects I, none selects V
    always_comb begin
        case (i_ir)
        mos6502_op_pkg::op_tax, mos6502_op_pkg::op_tsx, mos6502_op_pkg::op_inx,
        mos6502_op_pkg::op_dex, mos6502_op_pkg::op_ldx_i, mos6502_op_pkg::op_ldx_a:
            ds.dst_reg = mos6502_op_pkg::reg_x;
        mos6502_op_pkg::op_tay, mos6502_op_pkg::op_iny, mos6502_op_pkg::op_dey,
        mos6502_op_pkg::op_ldy_i, mos6502_op_pkg::op_ldy_a:
            ds.dst_reg = mos6502_op_pkg::reg_y;
        mos6502_op_pkg::op_txa, mos6502_op_pkg::op_tya, mos6502_op_pkg::op_asl_a,
        mos6502_op_pkg::op_lsr_a, mos6502_op_pkg::op_rol_a, mos6502_op_pkg::op_ror_a,
        mos6502_op_pkg::op_lda_i, mos6502_op_pkg::op_lda_a, mos6502_op_pkg::op_and_i,
        mos6502_op_pkg::op_sec, mos6502_op_pkg::op_clc:
            ds.dst_reg = mos6502_op_pkg::reg_ac;
        mos6502_op_pkg::op_txs, mos6502_op_pkg::op_sei, mos6502_op_pkg::op_cli:
            ds.dst_reg = mos6502_op_pkg::reg_s;
        default: ds.dst_reg = mos6502_op_pkg::reg_none;
        endcase
    end

    always_comb begin
        case (i_ir)
        mos6502_op_pkg::op_inx, mos6502_op_pkg::op_iny: ds.alu_op = mos6502_op_pkg::alu_inc;
        mos6502_op_pkg::op_dex, mos6502_op_pkg::op_dey: ds.alu_op = mos6502_op_pkg::alu_dec;
        mos6502_op_pkg::op_asl_a: ds.alu_op = mos6502_op_pkg::alu_asl;
        mos6502_op_pkg::op_lsr_a: ds.alu_op = mos6502_op_pkg::alu_lsr;
        mos6502_op_pkg::op_rol_a: ds.alu_op = mos6502_op_pkg::alu_rol;
        mos6502_op_pkg::op_ror_a: ds.alu_op = mos6502_op_pkg::alu_ror;
        mos6502_op_pkg::op_and_i: ds.alu_op = mos6502_op_pkg::alu_and;
        default: ds.alu_op = mos6502_op_pkg::alu_none;
        endcase
    end

endmodule

// File: hw/tcu_sequencer.sv
/*
 * T-state counter. Restarts at T0 on reset and after the last state of
 * the class seen in IR. IR must only change while T0 is presented.
 */
`timescale 1ns/10ps
`include "decoder_params.svh"

module tcu_sequencer (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mos6502_ctl_pkg::pstat_t i_p,
    decode_state_if.sequencer       ds
);

    mos6502_ctl_pkg::tcu_t last_t;
    logic                  is_rotate;

    // absolute addressing fetches two operand bytes before the access
    always_comb begin
        if (ds.op_class == mos6502_op_pkg::cls_load_abs ||
            ds.op_class == mos6502_op_pkg::cls_store_abs) begin
            last_t = mos6502_ctl_pkg::tcu_t'(`DEC_LEN_ABS);
        end else begin
            last_t = mos6502_ctl_pkg::tcu_t'(`DEC_LEN_SHORT);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ds.tcu <= '0;
        end else if (ds.tcu >= last_t) begin
            // end of opcode, fetch next
            ds.tcu <= '0;
        end else begin
            ds.tcu <= ds.tcu + 1'b1;
        end
    end

    assign is_rotate = (ds.alu_op == mos6502_op_pkg::alu_rol) ||
                       (ds.alu_op == mos6502_op_pkg::alu_ror);

    // old carry shifts into the rotated accumulator
    assign ds.carry_in = is_rotate ? i_p[`DEC_P_CARRY] : 1'b0;

endmodule

// File: hw/bus_route_ctl.sv
/*
 * PC, address bus and register transfer lines.
 * Outputs are combinational from the decode state, valid in the same cycle.
 */
`timescale 1ns/10ps

module bus_route_ctl (
    decode_state_if.route ds,
    output logic          o_rw,
    output logic          o_dl_db,
    output logic          o_dl_adh,
    output logic          o_pcl_pcl,
    output logic          o_i_pc,
    output logic          o_pcl_adl,
    output logic          o_pch_pch,
    output logic          o_pch_adh,
    output logic          o_adl_abl,
    output logic          o_adh_abh,
    output logic          o_x_sb,
    output logic          o_y_sb,
    output logic          o_ac_sb,
    output logic          o_ac_db,
    output logic          o_s_sb,
    output logic          o_add_sb_7,
    output logic          o_add_sb_0_6,
    output logic          o_add_adl,
    output logic          o_sb_db,
    output logic          o_sb_x,
    output logic          o_sb_y,
    output logic          o_sb_ac,
    output logic          o_sb_s
);

    logic t0, t1, t2, t3;
    logic is_abs, is_imm, is_load_abs, is_store_abs;
    logic alu_wb, pc_on_ab, abs_addr, src_on_sb, dst_from_sb, shift_via_db;

    assign t0 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(0));
    assign t1 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(1));
    assign t2 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(2));
    assign t3 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(3));

    assign is_load_abs  = (ds.op_class == mos6502_op_pkg::cls_load_abs);
    assign is_store_abs = (ds.op_class == mos6502_op_pkg::cls_store_abs);
    assign is_abs       = is_load_abs || is_store_abs;
    assign is_imm       = (ds.op_class == mos6502_op_pkg::cls_load_imm) ||
                          (ds.op_class == mos6502_op_pkg::cls_and_imm);

    // previous opcode finishes in T0 through ADD, IR still holds it
    assign alu_wb = t0 && (ds.alu_op != mos6502_op_pkg::alu_none);

    // fetch address comes from PC
    assign pc_on_ab = t0 || t1 || (t2 && is_abs);
    // effective address: low byte from ADD, high byte from DL
    assign abs_addr = t3 && is_abs;

    assign src_on_sb = t1 && (ds.op_class == mos6502_op_pkg::cls_transfer ||
                              ds.alu_op != mos6502_op_pkg::alu_none);
    assign dst_from_sb = alu_wb || (abs_addr && is_load_abs) ||
                         (t1 && (ds.op_class == mos6502_op_pkg::cls_transfer ||
                                 ds.op_class == mos6502_op_pkg::cls_load_imm));

    // ASL and ROL add AC to itself, so AC also reaches DB
    assign shift_via_db = t1 && (ds.alu_op == mos6502_op_pkg::alu_asl ||
                                 ds.alu_op == mos6502_op_pkg::alu_rol);

    assign o_pcl_adl = pc_on_ab;
    assign o_pch_adh = pc_on_ab;
    assign o_adl_abl = pc_on_ab || abs_addr;
    assign o_adh_abh = pc_on_ab || abs_addr;
    assign o_pcl_pcl = pc_on_ab || abs_addr;
    assign o_pch_pch = pc_on_ab || abs_addr;
    assign o_add_adl = abs_addr;
    assign o_dl_adh  = abs_addr;
    assign o_i_pc    = t0 || (t1 && (is_imm || is_abs)) || abs_addr;

    // operand byte from DL
    assign o_dl_db = (t1 && (is_imm || is_abs)) || (abs_addr && is_load_abs);

    assign o_ac_sb = src_on_sb && (ds.src_reg == mos6502_op_pkg::reg_ac);
    assign o_x_sb  = src_on_sb && (ds.src_reg == mos6502_op_pkg::reg_x);
    assign o_y_sb  = src_on_sb && (ds.src_reg == mos6502_op_pkg::reg_y);
    assign o_s_sb  = src_on_sb && (ds.src_reg == mos6502_op_pkg::reg_s);

    assign o_sb_ac = dst_from_sb && (ds.dst_reg == mos6502_op_pkg::reg_ac);
    assign o_sb_x  = dst_from_sb && (ds.dst_reg == mos6502_op_pkg::reg_x);
    assign o_sb_y  = dst_from_sb && (ds.dst_reg == mos6502_op_pkg::reg_y);
    assign o_sb_s  = dst_from_sb && (ds.dst_reg == mos6502_op_pkg::reg_s);

    // ALU result onto SB, or address low byte kept across T2
    assign o_add_sb_7   = alu_wb || (t2 && is_abs);
    assign o_add_sb_0_6 = alu_wb || (t2 && is_abs);

    // SB onto DB wherever Z and N are loaded from it
    assign o_sb_db = alu_wb || shift_via_db || (abs_addr && is_load_abs) ||
                     (t1 && ds.op_class == mos6502_op_pkg::cls_load_imm) ||
                     (t1 && ds.op_class == mos6502_op_pkg::cls_transfer &&
                      ds.dst_reg != mos6502_op_pkg::reg_s);

    assign o_ac_db = abs_addr && is_store_abs;
    assign o_rw    = (abs_addr && is_store_abs) ? mos6502_ctl_pkg::rw_write
                                                : mos6502_ctl_pkg::rw_read;

endmodule

// File: hw/alu_ctl.sv
/*
 * ALU input select, operation and status flag load lines.
 * Combinational from the decode state; carry_in is already 0 unless rotating.
 */
`timescale 1ns/10ps

module alu_ctl (
    decode_state_if.alu ds,
    output logic        o_db_n_add,
    output logic        o_db_add,
    output logic        o_0_add,
    output logic        o_sb_add,
    output logic        o_1_addc,
    output logic        o_sums,
    output logic        o_ands,
    output logic        o_srs,
    output logic        o_dbz_z,
    output logic        o_db7_n,
    output logic        o_acr_c,
    output logic        o_ir5_c,
    output logic        o_ir5_i,
    output logic        o_avr_v
);

    logic t0, t1, t2, t3;
    logic is_abs, alu_t1, flag_t1;
    logic op_inc, op_dec, op_left, op_right;

    assign t0 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(0));
    assign t1 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(1));
    assign t2 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(2));
    assign t3 = (ds.tcu == mos6502_ctl_pkg::tcu_t'(3));

    assign is_abs  = (ds.op_class == mos6502_op_pkg::cls_load_abs) ||
                     (ds.op_class == mos6502_op_pkg::cls_store_abs);
    assign alu_t1  = t1 && (ds.alu_op != mos6502_op_pkg::alu_none);
    assign flag_t1 = t1 && (ds.op_class == mos6502_op_pkg::cls_flag);

    assign op_inc   = (ds.alu_op == mos6502_op_pkg::alu_inc);
    assign op_dec   = (ds.alu_op == mos6502_op_pkg::alu_dec);
    assign op_left  = (ds.alu_op == mos6502_op_pkg::alu_asl) ||
                      (ds.alu_op == mos6502_op_pkg::alu_rol);
    assign op_right = (ds.alu_op == mos6502_op_pkg::alu_lsr) ||
                      (ds.alu_op == mos6502_op_pkg::alu_ror);

    // B input: precharged DB gives ff, inverted gives 00
    assign o_sb_add   = alu_t1 || (t2 && is_abs);
    assign o_db_n_add = (alu_t1 && op_inc) || (t2 && is_abs);
    assign o_db_add   = (alu_t1 && !op_inc && !op_right) || (t1 && is_abs);
    assign o_0_add    = t1 && is_abs;

    // carry in is +1 for INX/INY, old C for rotates
    assign o_1_addc = alu_t1 && (op_inc || ds.carry_in);
    assign o_sums   = (alu_t1 && (op_inc || op_dec || op_left)) ||
                      ((t1 || t2) && is_abs);
    assign o_srs    = alu_t1 && op_right;
    assign o_ands   = alu_t1 && (ds.alu_op == mos6502_op_pkg::alu_and);
    assign o_acr_c  = alu_t1 && (op_left || op_right);

    // Z and N follow DB, TXS leaves them alone
    assign o_dbz_z = (t0 && ds.alu_op != mos6502_op_pkg::alu_none) ||
                     (t1 && ds.op_class == mos6502_op_pkg::cls_load_imm) ||
                     (t3 && ds.op_class == mos6502_op_pkg::cls_load_abs) ||
                     (t1 && ds.op_class == mos6502_op_pkg::cls_transfer &&
                      ds.dst_reg != mos6502_op_pkg::reg_s);
    assign o_db7_n = o_dbz_z;

    // target flag as named by dst_reg
    assign o_ir5_c = flag_t1 && (ds.dst_reg == mos6502_op_pkg::reg_ac);
    assign o_ir5_i = flag_t1 && (ds.dst_reg == mos6502_op_pkg::reg_s);
    assign o_avr_v = flag_t1 && (ds.dst_reg == mos6502_op_pkg::reg_none);

endmodule

// File: hw/decoder_top.sv
/*
 * 6502 control decode for the supported subset, with its own T-state counter.
 * Control lines are combinational from T-state, IR and P in the same cycle.
 */
`timescale 1ns/10ps

module decoder_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mos6502_ctl_pkg::byte_t  i_ir,
    input  mos6502_ctl_pkg::pstat_t i_p,
    output mos6502_ctl_pkg::tcu_t   o_tcu,
    output logic                    o_rw,
    output logic                    o_dl_db,
    output logic                    o_dl_adh,
    output logic                    o_pcl_pcl,
    output logic                    o_i_pc,
    output logic                    o_pcl_adl,
    output logic                    o_pch_pch,
    output logic                    o_pch_adh,
    output logic                    o_x_sb,
    output logic                    o_y_sb,
    output logic                    o_ac_sb,
    output logic                    o_ac_db,
    output logic                    o_s_sb,
    output logic                    o_add_sb_7,
    output logic                    o_add_sb_0_6,
    output logic                    o_add_adl,
    output logic                    o_sb_db,
    output logic                    o_sb_x,
    output logic                    o_sb_y,
    output logic                    o_sb_ac,
    output logic                    o_sb_s,
    output logic                    o_adl_abl,
    output logic                    o_adh_abh,
    output logic                    o_db_n_add,
    output logic                    o_db_add,
    output logic                    o_0_add,
    output logic                    o_sb_add,
    output logic                    o_1_addc,
    output logic                    o_sums,
    output logic                    o_ands,
    output logic                    o_srs,
    output logic                    o_dbz_z,
    output logic                    o_db7_n,
    output logic                    o_acr_c,
    output logic                    o_ir5_c,
    output logic                    o_ir5_i,
    output logic                    o_avr_v
);

    decode_state_if ds ();

    // port names match the top level, ds included
    opcode_classifier opcode_classifier_i (.*);
    tcu_sequencer tcu_sequencer_i (.*);
    bus_route_ctl bus_route_ctl_i (.*);
    alu_ctl alu_ctl_i (.*);

    assign o_tcu = ds.tcu;

endmodule

// File: tb/decoder_tb.sv
/*
 * Self-checking testbench for the control decode. A new opcode is driven
 * only on the edge that leaves T0. Every control line is compared at the falling edge.
 */
`timescale 1ns/10ps
`include "decoder_params.svh"

module decoder_tb;

    // one field per DUT control output, in port order
    typedef struct packed {
        logic rw, dl_db, dl_adh, pcl_pcl, i_pc, pcl_adl, pch_pch, pch_adh;
        logic x_sb, y_sb, ac_sb, ac_db, s_sb, add_sb_7, add_sb_0_6, add_adl;
        logic sb_db, sb_x, sb_y, sb_ac, sb_s, adl_abl, adh_abh;
        logic db_n_add, db_add, zero_add, sb_add, one_addc, sums, ands, srs;
        logic dbz_z, db7_n, acr_c, ir5_c, ir5_i, avr_v;
    } ctl_t;

    localparam int fetch_timeout = 16;
    localparam mos6502_ctl_pkg::byte_t kept_ops [28] = '{
        8'hea, 8'haa, 8'ha8, 8'h8a, 8'h98, 8'h9a, 8'hba, 8'he8, 8'hc8, 8'hca,
        8'h88, 8'h0a, 8'h4a, 8'h2a, 8'h6a, 8'h38, 8'h18, 8'h78, 8'h58, 8'hb8,
        8'ha9, 8'ha2, 8'ha0, 8'h29, 8'had, 8'hae, 8'hac, 8'h8d
    };
    // BRK, an unused code, JMP abs and RTS are outside the decoded set
    localparam mos6502_ctl_pkg::byte_t unknown_ops [4] = '{8'h00, 8'hff, 8'h4c, 8'h60};

    logic                    i_clk;
    logic                    i_rst;
    mos6502_ctl_pkg::byte_t  i_ir;
    mos6502_ctl_pkg::pstat_t i_p;
    mos6502_ctl_pkg::tcu_t   o_tcu;
    logic o_rw, o_dl_db, o_dl_adh, o_pcl_pcl, o_i_pc, o_pcl_adl, o_pch_pch, o_pch_adh;
    logic o_x_sb, o_y_sb, o_ac_sb, o_ac_db, o_s_sb, o_add_sb_7, o_add_sb_0_6, o_add_adl;
    logic o_sb_db, o_sb_x, o_sb_y, o_sb_ac, o_sb_s, o_adl_abl, o_adh_abh;
    logic o_db_n_add, o_db_add, o_0_add, o_sb_add, o_1_addc, o_sums, o_ands, o_srs;
    logic o_dbz_z, o_db7_n, o_acr_c, o_ir5_c, o_ir5_i, o_avr_v;

    ctl_t                   dut_ctl;
    mos6502_ctl_pkg::tcu_t  exp_tcu;
    mos6502_ctl_pkg::byte_t wb_op;
    int                     errors = 0;
    int                     tests = 0;
    int                     failed = 0;
    logic                   timed_out = 1'b0;

    decoder_top decoder_top_i (.*);

    assign dut_ctl = {
        o_rw, o_dl_db, o_dl_adh, o_pcl_pcl, o_i_pc, o_pcl_adl, o_pch_pch, o_pch_adh,
        o_x_sb, o_y_sb, o_ac_sb, o_ac_db, o_s_sb, o_add_sb_7, o_add_sb_0_6, o_add_adl,
        o_sb_db, o_sb_x, o_sb_y, o_sb_ac, o_sb_s, o_adl_abl, o_adh_abh,
        o_db_n_add, o_db_add, o_0_add, o_sb_add, o_1_addc, o_sums, o_ands, o_srs,
        o_dbz_z, o_db7_n, o_acr_c, o_ir5_c, o_ir5_i, o_avr_v
    };

    function automatic logic is_abs(input mos6502_ctl_pkg::byte_t op);
        return op inside {8'had, 8'hae, 8'hac, 8'h8d};
    endfunction

    // opcodes whose result goes through the adder and is written back in T0
    function automatic logic uses_alu(input mos6502_ctl_pkg::byte_t op);
        return op inside {8'he8, 8'hc8, 8'hca, 8'h88, 8'h0a, 8'h4a, 8'h2a, 8'h6a, 8'h29};
    endfunction

    function automatic ctl_t expected_ctl(input mos6502_ctl_pkg::byte_t op,
                                          input mos6502_ctl_pkg::tcu_t t,
                                          input logic carry,
                                          input mos6502_ctl_pkg::byte_t prev_op);
        ctl_t v;
        logic abs_op;
        logic imm_op;
        logic pc_out;
        v = '0;
        abs_op = is_abs(op);
        imm_op = op inside {8'ha9, 8'ha2, 8'ha0, 8'h29};
        v.rw = 1'b1;
        // PC on the address bus while opcode and operands are fetched
        pc_out = (t == 0) || (t == 1) || (t == 2 && abs_op);
        v.pcl_adl = pc_out;
        v.pch_adh = pc_out;
        v.adl_abl = pc_out || (t == 3 && abs_op);
        v.adh_abh = v.adl_abl;
        v.pcl_pcl = v.adl_abl;
        v.pch_pch = v.adl_abl;
        if (t == 0) begin
            v.i_pc = 1'b1;
            // previous result leaves the adder through SB
            if (uses_alu(prev_op)) begin
                v.add_sb_7 = 1'b1;
                v.add_sb_0_6 = 1'b1;
                v.sb_db = 1'b1;
                v.dbz_z = 1'b1;
                v.db7_n = 1'b1;
                v.sb_x = prev_op inside {8'he8, 8'hca};
                v.sb_y = prev_op inside {8'hc8, 8'h88};
                v.sb_ac = prev_op inside {8'h0a, 8'h4a, 8'h2a, 8'h6a, 8'h29};
            end
        end else if (t == 1) begin
            v.i_pc = imm_op || abs_op;
            v.dl_db = imm_op || abs_op;
            v.ac_sb = op inside {8'haa, 8'ha8, 8'h0a, 8'h4a, 8'h2a, 8'h6a, 8'h29};
            v.x_sb = op inside {8'h8a, 8'h9a, 8'he8, 8'hca};
            v.y_sb = op inside {8'h98, 8'hc8, 8'h88};
            v.s_sb = (op == 8'hba);
            v.sb_x = op inside {8'haa, 8'hba, 8'ha2};
            v.sb_y = op inside {8'ha8, 8'ha0};
            v.sb_ac = op inside {8'h8a, 8'h98, 8'ha9};
            v.sb_s = (op == 8'h9a);
            // TXS leaves Z and N alone
            v.dbz_z = op inside {8'haa, 8'ha8, 8'h8a, 8'h98, 8'hba, 8'ha9, 8'ha2, 8'ha0};
            v.db7_n = v.dbz_z;
            v.sb_db = v.dbz_z || op inside {8'h0a, 8'h2a};
            v.sb_add = uses_alu(op);
            v.db_n_add = op inside {8'he8, 8'hc8};
            v.db_add = abs_op || op inside {8'hca, 8'h88, 8'h0a, 8'h2a, 8'h29};
            v.zero_add = abs_op;
            v.sums = abs_op || op inside {8'he8, 8'hc8, 8'hca, 8'h88, 8'h0a, 8'h2a};
            v.srs = op inside {8'h4a, 8'h6a};
            v.ands = (op == 8'h29);
            v.acr_c = op inside {8'h0a, 8'h4a, 8'h2a, 8'h6a};
            v.one_addc = op inside {8'he8, 8'hc8} || (carry && op inside {8'h2a, 8'h6a});
            v.ir5_c = op inside {8'h38, 8'h18};
            v.ir5_i = op inside {8'h78, 8'h58};
            v.avr_v = (op == 8'hb8);
        end else if (t == 2 && abs_op) begin
            v.add_sb_7 = 1'b1;
            v.add_sb_0_6 = 1'b1;
            v.sb_add = 1'b1;
            v.db_n_add = 1'b1;
            v.sums = 1'b1;
        end else if (t == 3 && abs_op) begin
            v.add_adl = 1'b1;
            v.dl_adh = 1'b1;
            v.i_pc = 1'b1;
            if (op == 8'h8d) begin
                v.ac_db = 1'b1;
                v.rw = 1'b0;
            end else begin
                v.dl_db = 1'b1;
                v.sb_db = 1'b1;
                v.dbz_z = 1'b1;
                v.db7_n = 1'b1;
                v.sb_ac = (op == 8'had);
                v.sb_x = (op == 8'hae);
                v.sb_y = (op == 8'hac);
            end
        end
        return v;
    endfunction

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // expected T-state and the opcode due for T0 writeback
    always @(posedge i_clk) begin
        if (i_rst) begin
            exp_tcu <= '0;
            wb_op <= i_ir;
        end else if (exp_tcu >= (is_abs(i_ir) ? `DEC_LEN_ABS : `DEC_LEN_SHORT)) begin
            exp_tcu <= '0;
            wb_op <= i_ir;
        end else begin
            exp_tcu <= exp_tcu + 1'b1;
        end
    end

    always @(negedge i_clk) begin : compare
        ctl_t exp_ctl;
        if (!i_rst) begin
            exp_ctl = expected_ctl(i_ir, exp_tcu, i_p[`DEC_P_CARRY], wb_op);
            if (o_tcu !== exp_tcu) begin
                $display("mismatch at %0t: ir %h tcu %0d, expected %0d",
                         $time, i_ir, o_tcu, exp_tcu);
                errors++;
            end
            if (dut_ctl !== exp_ctl) begin
                $display("mismatch at %0t: ir %h T%0d controls %h, expected %h",
                         $time, i_ir, exp_tcu, dut_ctl, exp_ctl);
                errors++;
            end
        end
    end

    task automatic wait_fetch(output int cycles);
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (o_tcu !== '0 && cycles < fetch_timeout);
        if (o_tcu !== '0) begin
            timed_out = 1'b1;
            $display("timeout: T0 not reached within %0d cycles at %0t", fetch_timeout, $time);
        end
    endtask

    // starts on the edge that leaves T0 and returns on the edge after the next T0
    task automatic run_op(input mos6502_ctl_pkg::byte_t op, input mos6502_ctl_pkg::pstat_t p);
        int cycles;
        int errs_before;
        int last_t;
        if (!timed_out) begin
            errs_before = errors;
            last_t = is_abs(op) ? `DEC_LEN_ABS : `DEC_LEN_SHORT;
            i_ir <= op;
            i_p <= p;
            wait_fetch(cycles);
            @(posedge i_clk);
            if (!timed_out && cycles != last_t + 1) begin
                $display("mismatch at %0t: op %h took %0d cycles, expected %0d",
                         $time, op, cycles, last_t + 1);
                errors++;
            end
            tests++;
            if (errors != errs_before) begin
                failed++;
            end
            $display("test %0d: op %h p %h, %0d cycles, %0d errors",
                     tests, op, p, cycles, errors - errs_before);
        end
    endtask

    initial begin
        int pick;
        mos6502_ctl_pkg::byte_t op;
        void'($urandom(32'h971d650a));
        i_rst = 1'b1;
        i_ir = 8'hea;
        i_p = 8'h00;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        if (o_tcu !== '0 || o_rw !== 1'b1 || o_i_pc !== 1'b1 || o_pcl_adl !== 1'b1) begin
            $display("mismatch at %0t: after reset tcu %0d rw %b i_pc %b pcl_adl %b",
                     $time, o_tcu, o_rw, o_i_pc, o_pcl_adl);
            errors++;
        end
        @(posedge i_clk);
        tests++;
        $display("test %0d: reset, %0d errors", tests, errors);
        if (errors != 0) begin
            failed++;
        end
        foreach (kept_ops[k]) begin
            run_op(kept_ops[k], mos6502_ctl_pkg::pstat_t'($urandom));
        end
        // a set carry must not reach ASL or LSR
        run_op(8'h0a, 8'h01);
        run_op(8'h4a, 8'hff);
        // rotates with both carry values
        run_op(8'h2a, 8'h01);
        run_op(8'h2a, 8'hfe);
        run_op(8'h6a, 8'h01);
        run_op(8'h6a, 8'h00);
        foreach (unknown_ops[k]) begin
            run_op(unknown_ops[k], mos6502_ctl_pkg::pstat_t'($urandom));
        end
        for (int n = 0; n < 40; n++) begin
            pick = $urandom_range(31, 0);
            op = (pick < 28) ? kept_ops[pick] : unknown_ops[pick - 28];
            run_op(op, mos6502_ctl_pkg::pstat_t'($urandom));
        end
        $display("tests %0d, failed %0d, mismatches %0d", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/mos6502_op_pkg.sv
hw/mos6502_ctl_pkg.sv
hw/decode_state_if.sv
hw/opcode_classifier.sv
hw/tcu_sequencer.sv
hw/bus_route_ctl.sv
hw/alu_ctl.sv
hw/decoder_top.sv
tb/decoder_tb.sv
